/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

    // RV32I major opcodes in instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_ARI_ITYPE = 7'b0010011,
        OPC_ARI_RTYPE = 7'b0110011
    } opcode_e;

    localparam logic [2:0] FNC_ADD_SUB = 3'b000;
    localparam logic [2:0] FNC_SLL     = 3'b001;
    localparam logic [2:0] FNC_SLT     = 3'b010;
    localparam logic [2:0] FNC_SLTU    = 3'b011;
    localparam logic [2:0] FNC_XOR     = 3'b100;
    localparam logic [2:0] FNC_SRL_SRA = 3'b101;
    localparam logic [2:0] FNC_OR      = 3'b110;
    localparam logic [2:0] FNC_AND     = 3'b111;

    localparam logic [2:0] FNC_BEQ     = 3'b000;
    localparam logic [2:0] FNC_BNE     = 3'b001;
    localparam logic [2:0] FNC_BLT     = 3'b100;
    localparam logic [2:0] FNC_BGE     = 3'b101;
    localparam logic [2:0] FNC_BLTU    = 3'b110;
    localparam logic [2:0] FNC_BGEU    = 3'b111;

    localparam logic FNC2_SUB = 1'b1;  // instr[30] for SUB and SRA/SRAI

endpackage

/* hw/core_ctrl_pkg.sv */
package core_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_ADD_SFT  // op_a + (op_b << shamt)
    } alu_op_e;

    typedef enum logic [1:0] {EXT_I, EXT_S, EXT_U, EXT_J} ext_sel_e;

    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} opa_sel_e;

    typedef enum logic {WB_ALU, WB_PC4} wb_sel_e;

    typedef struct packed {
        logic     reg_write;
        logic     imm_not_rs2;  // Operand B from immediate
        ext_sel_e ext_sel;
        opa_sel_e opa_sel;
        logic [4:0] shamt;
        wb_sel_e  wb_sel;
        logic     jump;
        logic     branch;
        alu_op_e  alu_op;
    } ctrl_t;

endpackage

/* hw/stage_if.sv */
`timescale 1ns/1ps

// Decode to execute
interface dx_if import core_ctrl_pkg::*; ();
    logic        valid;
    ctrl_t       ctrl;
    logic [31:0] pc;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] imm;
    logic [31:0] rs2_val;  // Raw rs2 for the branch compare
    logic [2:0]  funct3;
    logic [4:0]  rd;

    modport source (output valid, ctrl, pc, op_a, op_b, imm, rs2_val, funct3, rd);
    modport sink (input valid, ctrl, pc, op_a, op_b, imm, rs2_val, funct3, rd);
endinterface

// Execute to writeback
interface xw_if import core_ctrl_pkg::*; ();
    logic        valid;
    logic        reg_write;
    wb_sel_e     wb_sel;
    logic [4:0]  rd;
    logic [31:0] alu_result;
    logic [31:0] pc;

    modport source (output valid, reg_write, wb_sel, rd, alu_result, pc);
    modport sink (input valid, reg_write, wb_sel, rd, alu_result, pc);
endinterface

/* hw/control_path.sv */
`timescale 1ns/1ps

module control_path import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  opcode_e    opcode,
    input  logic [2:0] funct3,
    input  logic       inst_bit30,
    output ctrl_t      ctrl
);

    logic alu_class;  // ALU op comes from funct3

    always_comb begin
        ctrl.reg_write   = 1'b0;
        ctrl.imm_not_rs2 = 1'b0;
        ctrl.ext_sel     = EXT_I;
        ctrl.opa_sel     = OPA_RS1;
        ctrl.shamt       = 5'd0;
        ctrl.wb_sel      = WB_ALU;
        ctrl.jump        = 1'b0;
        ctrl.branch      = 1'b0;
        ctrl.alu_op      = ALU_ADD;
        alu_class        = 1'b0;

        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                ctrl.reg_write   = 1'b1;
                ctrl.imm_not_rs2 = 1'b1;
                ctrl.ext_sel     = EXT_U;
                ctrl.opa_sel     = (opcode == OPC_LUI) ? OPA_ZERO : OPA_PC;
                ctrl.shamt       = 5'd12;  // U immediate into bits 31:12
                ctrl.alu_op      = ALU_ADD_SFT;
            end
            OPC_JAL, OPC_JALR: begin
                ctrl.reg_write   = 1'b1;
                ctrl.imm_not_rs2 = 1'b1;
                ctrl.ext_sel     = (opcode == OPC_JAL) ? EXT_J : EXT_I;
                ctrl.opa_sel     = (opcode == OPC_JAL) ? OPA_PC : OPA_RS1;
                ctrl.wb_sel      = WB_PC4;
                ctrl.jump        = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.branch = 1'b1;  // Target formed from B immediate in execute
            end
            OPC_ARI_ITYPE: begin
                ctrl.reg_write   = 1'b1;
                ctrl.imm_not_rs2 = 1'b1;
                alu_class        = 1'b1;
            end
            OPC_ARI_RTYPE: begin
                ctrl.reg_write = 1'b1;
                alu_class      = 1'b1;
            end
            default: begin
                // LOAD, STORE and anything unknown stay a no-op
            end
        endcase

        if (alu_class) begin
            case (funct3)
                FNC_ADD_SUB: begin
                    if ((inst_bit30 == FNC2_SUB) && (opcode == OPC_ARI_RTYPE)) begin
                        ctrl.alu_op = ALU_SUB;
                    end else begin
                        ctrl.alu_op = ALU_ADD;  // ADDI ignores bit 30
                    end
                end
                FNC_SLL:     ctrl.alu_op = ALU_SLL;
                FNC_SLT:     ctrl.alu_op = ALU_SLT;
                FNC_SLTU:    ctrl.alu_op = ALU_SLTU;
                FNC_XOR:     ctrl.alu_op = ALU_XOR;
                FNC_SRL_SRA: ctrl.alu_op = (inst_bit30 == FNC2_SUB) ? ALU_SRA : ALU_SRL;
                FNC_OR:      ctrl.alu_op = ALU_OR;
                default:     ctrl.alu_op = ALU_AND;
            endcase
        end
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        we,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data
);

    localparam int AW = $clog2(REG_COUNT);

    logic [31:0] regs [REG_COUNT];
    logic        rs1_ok;
    logic        rs2_ok;

    // Register zero and registers above the count read as zero
    assign rs1_ok = (rs1_addr != 5'd0) && (int'(rs1_addr) < REG_COUNT);
    assign rs2_ok = (rs2_addr != 5'd0) && (int'(rs2_addr) < REG_COUNT);

    always_ff @(posedge clk) begin
        if (we && (int'(wr_addr) < REG_COUNT)) begin
            regs[wr_addr[AW-1:0]] <= wr_data;
        end
    end

    // Write-first bypass on both read ports
    assign rs1_data = !rs1_ok ? 32'd0 :
                      (we && (wr_addr == rs1_addr)) ? wr_data : regs[rs1_addr[AW-1:0]];
    assign rs2_data = !rs2_ok ? 32'd0 :
                      (we && (wr_addr == rs2_addr)) ? wr_data : regs[rs2_addr[AW-1:0]];

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import rv_isa_pkg::*, core_ctrl_pkg::*; #(
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] instr_pc,
    input  logic        fwd_valid,
    input  logic [4:0]  fwd_rd,
    input  logic [31:0] fwd_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    dx_if.source        dx
);

    opcode_e     opcode;
    ctrl_t       ctrl;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rf_rs1;
    logic [31:0] rf_rs2;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm;
    logic [31:0] op_a;

    assign opcode   = opcode_e'(instr[6:0]);
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    control_path u_ctrl (
        .opcode    (opcode),
        .funct3    (instr[14:12]),
        .inst_bit30(instr[30]),
        .ctrl      (ctrl)
    );

    reg_file #(.REG_COUNT(REG_COUNT)) u_rf (
        .clk     (clk),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rf_rs1),
        .rs2_data(rf_rs2),
        .we      (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    always_comb begin
        if (ctrl.branch) begin
            imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        end else begin
            case (ctrl.ext_sel)
                EXT_I: imm = {{20{instr[31]}}, instr[31:20]};
                EXT_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                EXT_U: imm = {12'd0, instr[31:12]};  // Shifted by 12 in the ALU
                EXT_J: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            endcase
        end
    end

    // Execute result wins over the register file
    assign rs1_val = (fwd_valid && (fwd_rd == rs1_addr) && (int'(rs1_addr) < REG_COUNT)) ?
                     fwd_data : rf_rs1;
    assign rs2_val = (fwd_valid && (fwd_rd == rs2_addr) && (int'(rs2_addr) < REG_COUNT)) ?
                     fwd_data : rf_rs2;

    always_comb begin
        case (ctrl.opa_sel)
            OPA_RS1: op_a = rs1_val;
            OPA_PC:  op_a = instr_pc;
            default: op_a = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dx.valid <= 1'b0;
        end else begin
            dx.valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        dx.ctrl    <= ctrl;
        dx.pc      <= instr_pc;
        dx.op_a    <= op_a;
        dx.op_b    <= ctrl.imm_not_rs2 ? imm : rs2_val;
        dx.imm     <= imm;
        dx.rs2_val <= rs2_val;
        dx.funct3  <= instr[14:12];
        dx.rd      <= instr[11:7];
    end

endmodule

/* hw/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    dx_if.sink          dx,
    xw_if.source        xw,
    output logic        fwd_valid,
    output logic [4:0]  fwd_rd,
    output logic [31:0] fwd_data,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    logic [31:0] alu_out;
    logic        taken;
    logic [31:0] target;
    logic        redirect_now;

    always_comb begin
        case (dx.ctrl.alu_op)
            ALU_ADD:     alu_out = dx.op_a + dx.op_b;
            ALU_SUB:     alu_out = dx.op_a - dx.op_b;
            ALU_SLL:     alu_out = dx.op_a << dx.op_b[4:0];
            ALU_SLT:     alu_out = {31'd0, $signed(dx.op_a) < $signed(dx.op_b)};
            ALU_SLTU:    alu_out = {31'd0, dx.op_a < dx.op_b};
            ALU_XOR:     alu_out = dx.op_a ^ dx.op_b;
            ALU_SRL:     alu_out = dx.op_a >> dx.op_b[4:0];
            ALU_SRA:     alu_out = $signed(dx.op_a) >>> dx.op_b[4:0];
            ALU_OR:      alu_out = dx.op_a | dx.op_b;
            ALU_AND:     alu_out = dx.op_a & dx.op_b;
            ALU_ADD_SFT: alu_out = dx.op_a + (dx.op_b << dx.ctrl.shamt);
            default:     alu_out = dx.op_a + dx.op_b;
        endcase
    end

    always_comb begin
        case (dx.funct3)
            FNC_BEQ:  taken = (dx.op_a == dx.rs2_val);
            FNC_BNE:  taken = (dx.op_a != dx.rs2_val);
            FNC_BLT:  taken = ($signed(dx.op_a) < $signed(dx.rs2_val));
            FNC_BGE:  taken = ($signed(dx.op_a) >= $signed(dx.rs2_val));
            FNC_BLTU: taken = (dx.op_a < dx.rs2_val);
            FNC_BGEU: taken = (dx.op_a >= dx.rs2_val);
            default:  taken = 1'b0;
        endcase
    end

    // JALR is the only jump with op_a from rs1
    always_comb begin
        if (dx.ctrl.branch) begin
            target = dx.pc + dx.imm;
        end else if (dx.ctrl.opa_sel == OPA_RS1) begin
            target = {alu_out[31:1], 1'b0};
        end else begin
            target = alu_out;
        end
    end

    assign redirect_now = dx.valid && (dx.ctrl.jump || (dx.ctrl.branch && taken));

    assign fwd_valid = dx.valid && dx.ctrl.reg_write && (dx.rd != 5'd0);
    assign fwd_rd    = dx.rd;
    assign fwd_data  = (dx.ctrl.wb_sel == WB_PC4) ? dx.pc + 32'd4 : alu_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xw.valid       <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            xw.valid       <= dx.valid;
            redirect_valid <= redirect_now;
        end
    end

    always_ff @(posedge clk) begin
        xw.reg_write  <= dx.ctrl.reg_write;
        xw.wb_sel     <= dx.ctrl.wb_sel;
        xw.rd         <= dx.rd;
        xw.alu_result <= alu_out;
        xw.pc         <= dx.pc;
        redirect_pc   <= target;
    end

endmodule

/* hw/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage import core_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    xw_if.sink          xw,
    output logic        wr_en,
    output logic [4:0]  wr_addr,
    output logic [31:0] wr_data,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    assign wr_data = (xw.wb_sel == WB_PC4) ? xw.pc + 32'd4 : xw.alu_result;
    assign wr_addr = xw.rd;
    assign wr_en   = xw.valid && xw.reg_write && (xw.rd != 5'd0);

    // Retire report mirrors the register write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= wr_addr;
        wb_data <= wr_data;
    end

endmodule

/* hw/rv_pipe_top.sv */
`timescale 1ns/1ps

module rv_pipe_top #(
    parameter int REG_COUNT = 32  // 16 for RV32E
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] instr_pc,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    logic        fwd_valid;
    logic [4:0]  fwd_rd;
    logic [31:0] fwd_data;
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;

    dx_if dx_bus ();
    xw_if xw_bus ();

    decode_stage #(.REG_COUNT(REG_COUNT)) u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_valid(instr_valid),
        .instr      (instr),
        .instr_pc   (instr_pc),
        .fwd_valid  (fwd_valid),
        .fwd_rd     (fwd_rd),
        .fwd_data   (fwd_data),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .dx         (dx_bus.source)
    );

    exec_stage u_exec (
        .clk           (clk),
        .rst_n         (rst_n),
        .dx            (dx_bus.sink),
        .xw            (xw_bus.source),
        .fwd_valid     (fwd_valid),
        .fwd_rd        (fwd_rd),
        .fwd_data      (fwd_data),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc)
    );

    writeback_stage u_wb (
        .clk     (clk),
        .rst_n   (rst_n),
        .xw      (xw_bus.sink),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wb_valid(wb_valid),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

endmodule

/* verification/rv_pipe_tb.sv */
`timescale 1ns/1ps

module rv_pipe_tb import rv_isa_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int NUM_INIT     = 62;  // LUI plus ADDI for x1 to x31
    localparam int NUM_RANDOM   = 400;
    localparam int NUM_INSTR    = NUM_INIT + NUM_RANDOM;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_INSTR + 20;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] instr_pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    int          cyc = 0;
    logic [15:0] lfsr = 16'd68;
    logic [4:0]  last_rd = 5'd0;
    logic [31:0] arch [32];  // Architectural register model

    int          red_due[$];
    logic [31:0] red_pc[$];
    string       red_name[$];
    int          wr_due[$];
    logic [4:0]  wr_rd[$];
    logic [31:0] wr_val[$];
    string       wr_name[$];

    rv_pipe_top #(.REG_COUNT(32)) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc)
    );

    always #20 clk = ~clk;

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_instr(output string name);
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [6:0]  f7;
        logic [6:0]  opc;
        logic [31:0] ins;
        kind = 3'(rand_bits(3));
        f3   = 3'(rand_bits(3));
        rd   = 5'(rand_bits(5));
        rs1  = 5'(rand_bits(5));
        rs2  = 5'(rand_bits(5));
        f7   = (rand_bits(1) == 1) ? 7'b0100000 : 7'b0000000;
        if (rand_bits(1) == 1) begin
            rs1 = last_rd;  // Chain on the previous result
        end
        case (kind)
            3'd0, 3'd1: begin
                name = "rtype";
                if ((f3 != FNC_ADD_SUB) && (f3 != FNC_SRL_SRA)) begin
                    f7 = 7'b0000000;
                end
                ins = {f7, rs2, rs1, f3, rd, OPC_ARI_RTYPE};
            end
            3'd2: begin
                name = "itype";
                if (f3 == FNC_SLL) begin
                    ins = {7'b0000000, rs2, rs1, f3, rd, OPC_ARI_ITYPE};
                end else if (f3 == FNC_SRL_SRA) begin
                    ins = {f7, rs2, rs1, f3, rd, OPC_ARI_ITYPE};  // SRAI by bit 30
                end else begin
                    ins = {12'(rand_bits(12)), rs1, f3, rd, OPC_ARI_ITYPE};
                end
            end
            3'd3: begin
                name = f3[0] ? "lui" : "auipc";
                opc  = f3[0] ? OPC_LUI : OPC_AUIPC;
                ins  = {20'(rand_bits(20)), rd, opc};
            end
            3'd4: begin
                name = "jal";
                ins  = {20'(rand_bits(20)), rd, OPC_JAL};
            end
            3'd5: begin
                name = "jalr";
                ins  = {12'(rand_bits(12)), rs1, 3'b000, rd, OPC_JALR};
            end
            3'd6: begin
                name = "branch";
                if (f3 == 3'b010) f3 = FNC_BEQ;
                if (f3 == 3'b011) f3 = FNC_BNE;
                if (rand_bits(1) == 1) begin
                    rs2 = rs1;  // Equal operands
                end
                ins = {7'(rand_bits(7)), rs2, rs1, f3, 5'(rand_bits(5)), OPC_BRANCH};
            end
            default: begin
                name = "noop";
                case (f3[1:0])
                    2'd0:    opc = OPC_LOAD;
                    2'd1:    opc = OPC_STORE;
                    2'd2:    opc = 7'b0001111;
                    default: opc = 7'b1110011;
                endcase
                ins = {25'(rand_bits(25)), opc};
            end
        endcase
        last_rd = rd;
        return ins;
    endfunction

    // In-order ISA model stepped once per instruction
    function automatic void ref_step(input logic [31:0] ins, input logic [31:0] pc,
                                     output logic wr, output logic [4:0] rd,
                                     output logic [31:0] val, output logic red,
                                     output logic [31:0] tgt);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] imm_b;
        logic [2:0]  f3;
        logic        is_r;
        rd    = ins[11:7];
        f3    = ins[14:12];
        a     = arch[ins[19:15]];
        b     = arch[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'd0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        is_r  = (ins[6:0] == OPC_ARI_RTYPE);
        wr    = 1'b0;
        red   = 1'b0;
        val   = 32'd0;
        tgt   = 32'd0;
        case (ins[6:0])
            OPC_LUI: begin
                wr  = 1'b1;
                val = imm_u;
            end
            OPC_AUIPC: begin
                wr  = 1'b1;
                val = pc + imm_u;
            end
            OPC_JAL: begin
                wr  = 1'b1;
                val = pc + 32'd4;
                red = 1'b1;
                tgt = pc + imm_j;
            end
            OPC_JALR: begin
                wr  = 1'b1;
                val = pc + 32'd4;
                red = 1'b1;
                tgt = (a + imm_i) & 32'hFFFF_FFFE;
            end
            OPC_BRANCH: begin
                tgt = pc + imm_b;
                case (f3)
                    FNC_BEQ:  red = (a == b);
                    FNC_BNE:  red = (a != b);
                    FNC_BLT:  red = ($signed(a) < $signed(b));
                    FNC_BGE:  red = ($signed(a) >= $signed(b));
                    FNC_BLTU: red = (a < b);
                    FNC_BGEU: red = (a >= b);
                    default:  red = 1'b0;
                endcase
            end
            OPC_ARI_ITYPE, OPC_ARI_RTYPE: begin
                wr = 1'b1;
                if (!is_r) b = imm_i;
                case (f3)
                    FNC_ADD_SUB: val = (is_r && ins[30]) ? a - b : a + b;
                    FNC_SLL:     val = a << b[4:0];
                    FNC_SLT:     val = {31'd0, $signed(a) < $signed(b)};
                    FNC_SLTU:    val = {31'd0, a < b};
                    FNC_XOR:     val = a ^ b;
                    FNC_SRL_SRA: begin
                        if (ins[30]) val = $signed(a) >>> b[4:0];
                        else val = a >> b[4:0];
                    end
                    FNC_OR:      val = a | b;
                    default:     val = a & b;
                endcase
            end
            default: begin
                wr = 1'b0;  // LOAD, STORE and unknown opcodes
            end
        endcase
        if (rd == 5'd0) wr = 1'b0;
        if (wr) arch[rd] = val;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic check_write(input string name, input logic [4:0] exp_rd,
                               input logic [31:0] exp_data, input logic [4:0] act_rd,
                               input logic [31:0] act_data);
        if ((act_rd !== exp_rd) || (act_data !== exp_data)) begin
            stop_with_failure($sformatf("Error %s: expected x%0d = %h, actual x%0d = %h",
                                        name, exp_rd, exp_data, act_rd, act_data));
        end
    endtask

    task automatic check_redirect(input string name, input logic [31:0] exp_pc,
                                  input logic [31:0] act_pc);
        if (act_pc !== exp_pc) begin
            stop_with_failure($sformatf("Error %s: expected target %h, actual target %h",
                                        name, exp_pc, act_pc));
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            stop_with_failure($sformatf("Timeout: run still busy after %0d cycles", cyc));
        end
    end

    // Outputs are sampled mid-cycle against the due cycle of each expected item
    always @(negedge clk) begin
        if (cyc >= RESET_CYCLES) begin
            if ((red_due.size() > 0) && (red_due[0] == cyc)) begin
                if (redirect_valid !== 1'b1) begin
                    stop_with_failure($sformatf("No redirect reported for %s at cycle %0d",
                                                red_name[0], cyc));
                end
                check_redirect(red_name[0], red_pc[0], redirect_pc);
                void'(red_due.pop_front());
                void'(red_pc.pop_front());
                void'(red_name.pop_front());
            end else if (redirect_valid !== 1'b0) begin
                stop_with_failure($sformatf("Redirect reported with none due at cycle %0d", cyc));
            end
            if ((wr_due.size() > 0) && (wr_due[0] == cyc)) begin
                if (wb_valid !== 1'b1) begin
                    stop_with_failure($sformatf("No register write reported for %s at cycle %0d",
                                                wr_name[0], cyc));
                end
                check_write(wr_name[0], wr_rd[0], wr_val[0], wb_rd, wb_data);
                void'(wr_due.pop_front());
                void'(wr_rd.pop_front());
                void'(wr_val.pop_front());
                void'(wr_name.pop_front());
            end else if (wb_valid !== 1'b0) begin
                stop_with_failure($sformatf("Register write reported with none due at cycle %0d",
                                            cyc));
            end
        end
    end

    initial begin
        logic [31:0] ins;
        logic [31:0] pc;
        logic [4:0]  r;
        string       name;
        logic        exp_wr;
        logic        exp_red;
        logic [4:0]  exp_rd;
        logic [31:0] exp_val;
        logic [31:0] exp_tgt;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'd0;
        instr_pc    = 32'd0;
        pc          = 32'h0000_1000;
        for (int k = 0; k < 32; k++) begin
            arch[k] = 32'd0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < NUM_INSTR; i++) begin
            @(negedge clk);
            if (i < NUM_INIT) begin
                name = "init";
                r    = 5'(i / 2 + 1);
                if (i % 2 == 0) ins = {20'(rand_bits(20)), r, OPC_LUI};
                else ins = {12'(rand_bits(12)), r, FNC_ADD_SUB, r, OPC_ARI_ITYPE};
            end else begin
                ins = make_instr(name);
            end
            ref_step(ins, pc, exp_wr, exp_rd, exp_val, exp_red, exp_tgt);
            if (exp_red) begin
                red_due.push_back(cyc + 2);
                red_pc.push_back(exp_tgt);
                red_name.push_back(name);
            end
            if (exp_wr) begin
                wr_due.push_back(cyc + 3);
                wr_rd.push_back(exp_rd);
                wr_val.push_back(exp_val);
                wr_name.push_back(name);
            end
            instr_valid = 1'b1;
            instr       = ins;
            instr_pc    = pc;
            pc          = pc + 32'd4;
        end
        @(negedge clk);
        instr_valid = 1'b0;
        while ((red_due.size() > 0) || (wr_due.size() > 0)) @(negedge clk);
        repeat (3) @(negedge clk);  // Catch stray valids after the last retire
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* verilog.f */
hw/rv_isa_pkg.sv
hw/core_ctrl_pkg.sv
hw/stage_if.sv
hw/control_path.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/exec_stage.sv
hw/writeback_stage.sv
hw/rv_pipe_top.sv
verification/rv_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rv_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --top-module rv_pipe_tb -f verilog.f --Mdir "$BUILD" -o rv_pipe_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/rv_pipe_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "PASS: all tests" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
